// ==== hw/coreExePkg.sv ====
// Types and encodings shared by all stages of the RV32I execute slice; imported by each module
`default_nettype none

package coreExePkg;

  // ========================================
  // Opcodes
  // ========================================
  localparam logic [6:0] OpReg    = 7'b0110011; // R-type ALU
  localparam logic [6:0] OpImm    = 7'b0010011; // I-type ALU and shifts
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpAuipc  = 7'b0010111;
  localparam logic [6:0] OpBranch = 7'b1100011; // All six conditional branches

  // ========================================
  // ALU and branch encodings
  // ========================================
  typedef enum logic [3:0] {
    ADD,  // Also AUIPC and branch target
    SUB,
    SLT,
    SLTU,
    SLL,
    SRL,
    SRA,
    XOR,
    OR,
    AND
  } tAluOp;

  typedef enum logic [2:0] {
    BEQ,
    BNE,
    BLT,
    BGE,
    BLTU,
    BGEU,
    NONE  // Not a branch
  } tBranchOp;

  // ========================================
  // Stage payloads
  // ========================================
  typedef struct packed {
    logic [31:0] Instr;  // Raw instruction word
    logic [31:0] Pc;
  } tInst;

  typedef struct packed {
    logic [4:0] RegSrc1;
    logic [4:0] RegSrc2;
    logic [4:0] RegDst;
    logic       RegWrEn;
    logic       SelAluPc;   // ALU input 1 takes Pc
    logic       SelAluImm;  // ALU input 2 takes the immediate
    logic       Lui;        // Result is the immediate itself
    tAluOp      AluOp;
    tBranchOp   BranchOp;
    logic       Valid;
  } tCtrlExe;

  typedef struct packed {
    logic [31:0] PreRegRdData1;  // Register file values before forwarding
    logic [31:0] PreRegRdData2;
    logic [31:0] Pc;
    logic [31:0] Immediate;
  } tDataExe;

  // Forwarding view of a later stage
  typedef struct packed {
    logic [4:0] RegDst;
    logic       RegWrEn;
    logic       Valid;
  } tWbCtrl;

  typedef struct packed {
    logic [4:0]  Rd;
    logic        RegWrEn;
    logic [31:0] Data;  // ALU result or branch target
    logic        IsBranch;
    logic        BranchTaken;
    logic [31:0] PcPlus4;
    logic [31:0] Pc;
  } tResult;

  typedef struct packed {
    logic   Valid;
    tResult Res;
  } tStageQ10x;

endpackage

`default_nettype wire

// ==== hw/regFile.sv ====
// Integer register file: two combinational read ports, one write port, same-cycle write-through
`timescale 1ns/100ps
`default_nettype none

module regFile #(
  parameter int NumRegs = 32
) (
  input  var logic        Clock,
  input  var logic        arstN,
  input  var logic [4:0]  RdAddr1,
  input  var logic [4:0]  RdAddr2,
  output logic [31:0]     RdData1,
  output logic [31:0]     RdData2,
  input  var logic        WrEn,     // Only on a retiring transfer
  input  var logic [4:0]  WrAddr,
  input  var logic [31:0] WrData
);

  logic [31:0] Regs [NumRegs];

  // Array cleared on reset so early reads are defined
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        Regs[i] <= '0;
      end
    end else if (WrEn && (WrAddr != 5'd0)) begin
      Regs[WrAddr] <= WrData;
    end
  end

  // x0 hardwired, then bypass the write in flight
  always_comb begin : readPorts
    RdData1 = (RdAddr1 == 5'd0)                 ? 32'd0  :
              (WrEn && (WrAddr == RdAddr1))     ? WrData : Regs[RdAddr1];
    RdData2 = (RdAddr2 == 5'd0)                 ? 32'd0  :
              (WrEn && (WrAddr == RdAddr2))     ? WrData : Regs[RdAddr2];
  end

endmodule

`default_nettype wire

// ==== hw/instDecode.sv ====
// Q101H stage: holds the accepted instruction, decodes it, reads operands and registers Q102H
`timescale 1ns/100ps
`default_nettype none

module instDecode (
  input  var logic                 Clock,
  input  var logic                 arstN,
  input  var logic                 Ready,      // Global stage enable
  input  var logic                 InstValid,
  input  var coreExePkg::tInst     InstData,
  output logic [4:0]               RdAddr1,    // To register file
  output logic [4:0]               RdAddr2,
  input  var logic [31:0]          RdData1,    // Write-through already applied
  input  var logic [31:0]          RdData2,
  output coreExePkg::tCtrlExe      CtrlQ102H,
  output coreExePkg::tDataExe      DataQ102H
);
  import coreExePkg::*;

  logic        ValidQ101H;
  tInst        InstQ101H;
  logic [6:0]  OpcodeQ101H;
  logic [2:0]  Funct3Q101H;
  logic        AltQ101H;   // funct7 bit 5, picks SUB and SRA
  logic [31:0] ImmQ101H;
  tCtrlExe     CtrlQ101H;
  tDataExe     DataQ101H;

  // Arithmetic op from funct3, Alt selects SUB or SRA
  function automatic tAluOp aluOpOf(input logic [2:0] Funct3, input logic Alt);
    case (Funct3)
      3'b000:  return Alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return Alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  // ========================================
  // Q101H instruction register
  // ========================================
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      ValidQ101H <= 1'b0;
    end else if (Ready) begin
      ValidQ101H <= InstValid;  // Bubble when nothing offered
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      InstQ101H <= InstData;
    end
  end

  assign OpcodeQ101H = InstQ101H.Instr[6:0];
  assign Funct3Q101H = InstQ101H.Instr[14:12];
  assign AltQ101H    = InstQ101H.Instr[30];

  always_comb begin : decode
    CtrlQ101H          = '0;
    CtrlQ101H.AluOp    = ADD;
    CtrlQ101H.BranchOp = NONE;
    ImmQ101H           = '0;
    case (OpcodeQ101H)
      OpReg: begin
        CtrlQ101H.RegSrc1 = InstQ101H.Instr[19:15];
        CtrlQ101H.RegSrc2 = InstQ101H.Instr[24:20];
        CtrlQ101H.RegWrEn = 1'b1;
        CtrlQ101H.AluOp   = aluOpOf(Funct3Q101H, AltQ101H);
      end
      OpImm: begin
        CtrlQ101H.RegSrc1   = InstQ101H.Instr[19:15];
        CtrlQ101H.RegWrEn   = 1'b1;
        CtrlQ101H.SelAluImm = 1'b1;
        // No SUBI, Alt only matters for SRAI
        CtrlQ101H.AluOp     = aluOpOf(Funct3Q101H, AltQ101H && (Funct3Q101H == 3'b101));
        ImmQ101H            = {{20{InstQ101H.Instr[31]}}, InstQ101H.Instr[31:20]};
      end
      OpLui: begin
        CtrlQ101H.RegWrEn   = 1'b1;
        CtrlQ101H.SelAluImm = 1'b1;
        CtrlQ101H.Lui       = 1'b1;
        ImmQ101H            = {InstQ101H.Instr[31:12], 12'b0};
      end
      OpAuipc: begin
        CtrlQ101H.RegWrEn   = 1'b1;
        CtrlQ101H.SelAluPc  = 1'b1;  // Pc + U immediate
        CtrlQ101H.SelAluImm = 1'b1;
        ImmQ101H            = {InstQ101H.Instr[31:12], 12'b0};
      end
      OpBranch: begin
        CtrlQ101H.RegSrc1   = InstQ101H.Instr[19:15];
        CtrlQ101H.RegSrc2   = InstQ101H.Instr[24:20];
        CtrlQ101H.SelAluPc  = 1'b1;  // ALU makes the target
        CtrlQ101H.SelAluImm = 1'b1;
        case (Funct3Q101H)
          3'b000:  CtrlQ101H.BranchOp = BEQ;
          3'b001:  CtrlQ101H.BranchOp = BNE;
          3'b100:  CtrlQ101H.BranchOp = BLT;
          3'b101:  CtrlQ101H.BranchOp = BGE;
          3'b110:  CtrlQ101H.BranchOp = BLTU;
          3'b111:  CtrlQ101H.BranchOp = BGEU;
          default: CtrlQ101H.BranchOp = NONE;
        endcase
        ImmQ101H = {{19{InstQ101H.Instr[31]}}, InstQ101H.Instr[31], InstQ101H.Instr[7],
                    InstQ101H.Instr[30:25], InstQ101H.Instr[11:8], 1'b0};
      end
      default: ;  // Unsupported, retires as no-op
    endcase
    CtrlQ101H.RegDst = CtrlQ101H.RegWrEn ? InstQ101H.Instr[11:7] : 5'd0;
    CtrlQ101H.Valid  = ValidQ101H;
  end

  assign RdAddr1   = CtrlQ101H.RegSrc1;
  assign RdAddr2   = CtrlQ101H.RegSrc2;
  assign DataQ101H = '{PreRegRdData1: RdData1, PreRegRdData2: RdData2,
                       Pc: InstQ101H.Pc, Immediate: ImmQ101H};

  // Q101H to Q102H
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      CtrlQ102H <= '0;
    end else if (Ready) begin
      CtrlQ102H <= CtrlQ101H;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      DataQ102H <= DataQ101H;
    end
  end

endmodule

`default_nettype wire

// ==== hw/intExecute.sv ====
// Q102H execute stage: hazard check, three-level forwarding, ALU and branch compare into Q103H
`timescale 1ns/100ps
`default_nettype none

module intExecute (
  input  var logic                 Clock,
  input  var logic                 arstN,
  input  var logic                 Ready,
  input  var coreExePkg::tCtrlExe  CtrlQ102H,
  input  var coreExePkg::tDataExe  DataQ102H,
  input  var coreExePkg::tWbCtrl   WbCtrlQ103H,    // Youngest producer
  input  var coreExePkg::tWbCtrl   WbCtrlQ104H,
  input  var coreExePkg::tWbCtrl   WbCtrlQ105H,    // Oldest, about to write
  input  var logic [31:0]          AluOutQ104H,
  input  var logic [31:0]          RegWrDataQ105H,
  output coreExePkg::tStageQ10x    StageQ103H,
  output logic [31:0]              AluOutQ103H
);
  import coreExePkg::*;

  logic        Hazard1Src1Q102H, Hazard2Src1Q102H, Hazard3Src1Q102H;
  logic        Hazard1Src2Q102H, Hazard2Src2Q102H, Hazard3Src2Q102H;
  logic [31:0] RegRdData1Q102H, RegRdData2Q102H;
  logic [31:0] AluIn1Q102H, AluIn2Q102H;
  logic [4:0]  ShamtQ102H;
  logic [31:0] AluOutQ102H;
  logic        BranchTakenQ102H;
  tResult      ResQ102H;
  logic        ValidQ103H;
  tResult      ResQ103H;

  // Producer in a later stage writes the register we read
  function automatic logic hitWb(input logic [4:0] Src, input tWbCtrl Wb);
    return Wb.Valid && Wb.RegWrEn && (Wb.RegDst == Src) && (Src != 5'd0);
  endfunction

  // ========================================
  // Hazard detection and forwarding
  // ========================================
  assign Hazard1Src1Q102H = hitWb(CtrlQ102H.RegSrc1, WbCtrlQ103H);
  assign Hazard2Src1Q102H = hitWb(CtrlQ102H.RegSrc1, WbCtrlQ104H);
  assign Hazard3Src1Q102H = hitWb(CtrlQ102H.RegSrc1, WbCtrlQ105H);
  assign Hazard1Src2Q102H = hitWb(CtrlQ102H.RegSrc2, WbCtrlQ103H);
  assign Hazard2Src2Q102H = hitWb(CtrlQ102H.RegSrc2, WbCtrlQ104H);
  assign Hazard3Src2Q102H = hitWb(CtrlQ102H.RegSrc2, WbCtrlQ105H);

  // Youngest match wins
  assign RegRdData1Q102H = Hazard1Src1Q102H ? AluOutQ103H    :
                           Hazard2Src1Q102H ? AluOutQ104H    :
                           Hazard3Src1Q102H ? RegWrDataQ105H :
                                              DataQ102H.PreRegRdData1;  // No hazard
  assign RegRdData2Q102H = Hazard1Src2Q102H ? AluOutQ103H    :
                           Hazard2Src2Q102H ? AluOutQ104H    :
                           Hazard3Src2Q102H ? RegWrDataQ105H :
                                              DataQ102H.PreRegRdData2;

  assign AluIn1Q102H = CtrlQ102H.SelAluPc  ? DataQ102H.Pc        : RegRdData1Q102H;
  assign AluIn2Q102H = CtrlQ102H.SelAluImm ? DataQ102H.Immediate : RegRdData2Q102H;
  assign ShamtQ102H  = AluIn2Q102H[4:0];  // Low five bits only

  // ========================================
  // ALU and branch compare
  // ========================================
  always_comb begin : alu
    case (CtrlQ102H.AluOp)
      ADD:     AluOutQ102H = AluIn1Q102H + AluIn2Q102H;  // Also target for branches
      SUB:     AluOutQ102H = AluIn1Q102H - AluIn2Q102H;
      SLT:     AluOutQ102H = {31'b0, $signed(AluIn1Q102H) < $signed(AluIn2Q102H)};
      SLTU:    AluOutQ102H = {31'b0, AluIn1Q102H < AluIn2Q102H};
      SLL:     AluOutQ102H = AluIn1Q102H << ShamtQ102H;
      SRL:     AluOutQ102H = AluIn1Q102H >> ShamtQ102H;
      SRA:     AluOutQ102H = $signed(AluIn1Q102H) >>> ShamtQ102H;
      XOR:     AluOutQ102H = AluIn1Q102H ^ AluIn2Q102H;
      OR:      AluOutQ102H = AluIn1Q102H | AluIn2Q102H;
      AND:     AluOutQ102H = AluIn1Q102H & AluIn2Q102H;
      default: AluOutQ102H = AluIn1Q102H + AluIn2Q102H;
    endcase
    if (CtrlQ102H.Lui) begin
      AluOutQ102H = AluIn2Q102H;  // LUI passes the U immediate
    end
  end

  always_comb begin : branchCmp
    case (CtrlQ102H.BranchOp)
      BEQ:     BranchTakenQ102H =  (RegRdData1Q102H == RegRdData2Q102H);
      BNE:     BranchTakenQ102H = !(RegRdData1Q102H == RegRdData2Q102H);
      BLT:     BranchTakenQ102H =  ($signed(RegRdData1Q102H) < $signed(RegRdData2Q102H));
      BGE:     BranchTakenQ102H = !($signed(RegRdData1Q102H) < $signed(RegRdData2Q102H));
      BLTU:    BranchTakenQ102H =  (RegRdData1Q102H < RegRdData2Q102H);
      BGEU:    BranchTakenQ102H = !(RegRdData1Q102H < RegRdData2Q102H);
      default: BranchTakenQ102H = 1'b0;  // NONE
    endcase
  end

  assign ResQ102H = '{Rd: CtrlQ102H.RegDst, RegWrEn: CtrlQ102H.RegWrEn, Data: AluOutQ102H,
                      IsBranch: (CtrlQ102H.BranchOp != NONE), BranchTaken: BranchTakenQ102H,
                      PcPlus4: DataQ102H.Pc + 32'd4, Pc: DataQ102H.Pc};

  // Q102H to Q103H
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      ValidQ103H <= 1'b0;
    end else if (Ready) begin
      ValidQ103H <= CtrlQ102H.Valid;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      ResQ103H <= ResQ102H;
    end
  end

  assign StageQ103H  = '{Valid: ValidQ103H, Res: ResQ103H};
  assign AluOutQ103H = ResQ103H.Data;  // Forwarded back into Q102H

endmodule

`default_nettype wire

// ==== hw/retireStage.sv ====
// Q103H to Q105H result pipe: forwarding taps, register write-back and the result output stream
`timescale 1ns/100ps
`default_nettype none

module retireStage (
  input  var logic                   Clock,
  input  var logic                   arstN,
  input  var logic                   Ready,
  input  var coreExePkg::tStageQ10x  StageQ103H,
  output coreExePkg::tWbCtrl         WbCtrlQ103H,
  output coreExePkg::tWbCtrl         WbCtrlQ104H,
  output coreExePkg::tWbCtrl         WbCtrlQ105H,
  output logic [31:0]                AluOutQ104H,
  output logic [31:0]                RegWrDataQ105H,
  output logic                       WrEn,         // Register file write port
  output logic [4:0]                 WrAddr,
  output logic [31:0]                WrData,
  output logic                       ResultValid,
  input  var logic                   ResultReady,
  output coreExePkg::tResult         ResultData
);
  import coreExePkg::*;

  logic   ValidQ104H, ValidQ105H;
  tResult ResQ104H, ResQ105H;

  // ========================================
  // Result pipe
  // ========================================
  always_ff @(posedge Clock or negedge arstN) begin
    if (!arstN) begin
      ValidQ104H <= 1'b0;
      ValidQ105H <= 1'b0;
    end else if (Ready) begin
      ValidQ104H <= StageQ103H.Valid;
      ValidQ105H <= ValidQ104H;
    end
  end

  always_ff @(posedge Clock) begin
    if (Ready) begin
      ResQ104H <= StageQ103H.Res;
      ResQ105H <= ResQ104H;
    end
  end

  // Forwarding taps, one per stage
  assign WbCtrlQ103H = '{RegDst: StageQ103H.Res.Rd, RegWrEn: StageQ103H.Res.RegWrEn,
                         Valid: StageQ103H.Valid};
  assign WbCtrlQ104H = '{RegDst: ResQ104H.Rd, RegWrEn: ResQ104H.RegWrEn, Valid: ValidQ104H};
  assign WbCtrlQ105H = '{RegDst: ResQ105H.Rd, RegWrEn: ResQ105H.RegWrEn, Valid: ValidQ105H};
  assign AluOutQ104H    = ResQ104H.Data;
  assign RegWrDataQ105H = ResQ105H.Data;

  // ========================================
  // Write-back and output stream
  // ========================================
  // Write lands on the same edge the record leaves
  assign WrEn   = ValidQ105H && ResultReady && ResQ105H.RegWrEn && (ResQ105H.Rd != 5'd0);
  assign WrAddr = ResQ105H.Rd;
  assign WrData = ResQ105H.Data;

  assign ResultValid = ValidQ105H;
  assign ResultData  = ResQ105H;  // Full record, flags included

endmodule

`default_nettype wire

// ==== hw/coreExeTop.sv ====
// Top of the RV32I execute slice: wires the four stages and derives the global stall enable
`timescale 1ns/100ps
`default_nettype none

module coreExeTop #(
  parameter int NumRegs = 32
) (
  input  var logic                Clock,
  input  var logic                arstN,
  input  var logic                InstValid,
  output logic                    InstReady,
  input  var coreExePkg::tInst    InstData,
  output logic                    ResultValid,
  input  var logic                ResultReady,
  output coreExePkg::tResult      ResultData
);
  import coreExePkg::*;

  logic        Ready;  // Enables every stage register
  logic [4:0]  RdAddr1, RdAddr2;
  logic [31:0] RdData1, RdData2;
  tCtrlExe     CtrlQ102H;
  tDataExe     DataQ102H;
  tStageQ10x   StageQ103H;
  logic [31:0] AluOutQ103H, AluOutQ104H, RegWrDataQ105H;
  tWbCtrl      WbCtrlQ103H, WbCtrlQ104H, WbCtrlQ105H;
  logic        WrEn;
  logic [4:0]  WrAddr;
  logic [31:0] WrData;

  // Whole pipe moves unless the output record is stuck
  assign Ready     = !ResultValid || ResultReady;
  assign InstReady = Ready;

  // ========================================
  // Stages
  // ========================================
  instDecode instDecode0 (
    .Clock, .arstN, .Ready, .InstValid, .InstData,
    .RdAddr1, .RdAddr2, .RdData1, .RdData2,
    .CtrlQ102H, .DataQ102H
  );

  regFile #(.NumRegs(NumRegs)) regFile0 (
    .Clock, .arstN, .RdAddr1, .RdAddr2, .RdData1, .RdData2,
    .WrEn, .WrAddr, .WrData
  );

  intExecute intExecute0 (
    .Clock, .arstN, .Ready, .CtrlQ102H, .DataQ102H,
    .WbCtrlQ103H, .WbCtrlQ104H, .WbCtrlQ105H,
    .AluOutQ104H, .RegWrDataQ105H, .StageQ103H, .AluOutQ103H
  );

  retireStage retireStage0 (
    .Clock, .arstN, .Ready, .StageQ103H,
    .WbCtrlQ103H, .WbCtrlQ104H, .WbCtrlQ105H,
    .AluOutQ104H, .RegWrDataQ105H,
    .WrEn, .WrAddr, .WrData,
    .ResultValid, .ResultReady, .ResultData
  );

endmodule

`default_nettype wire

// ==== bench/coreExeTests.svh ====
// Directed tests for the execute slice, included inside the testbench module body
`ifndef CORE_EXE_TESTS_SVH
`define CORE_EXE_TESTS_SVH
`default_nettype none

// ========================================
// Instruction encoders
// ========================================
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, OpReg};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] f3,
                                     input logic [4:0] rd, input logic [4:0] rs1);
  return {imm, rs1, f3, rd, OpImm};
endfunction

function automatic logic [31:0] encU(input logic [6:0] op, input logic [19:0] imm,
                                     input logic [4:0] rd);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                     input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OpBranch};
endfunction

// LUI then ADDI, upper part rounded for the sign of the low twelve bits
task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
  sendInst(encU(OpLui, value[31:12] + value[11], rd));
  sendInst(encI(value[11:0], 3'b000, rd, rd));
endtask

// ========================================
// Tests
// ========================================
task automatic resetStateTest();
  int n;
  check(ResultValid, 1'b0, "ResultValid after reset");
  check(InstReady, 1'b1, "InstReady after reset");
  sendInst(encI(12'd5, 3'b000, 5'd1, 5'd0));
  n = 0;
  while (!ResultValid && (n < 16)) begin
    @(posedge Clock);
    #10;
    n++;
  end
  check(n, 4, "latency in cycles");
  drain();
endtask

task automatic aluTest();
  logic [31:0] r;
  for (int round = 0; round < 2; round++) begin
    randWord(32, r);
    loadReg(5'd1, r);
    randWord(32, r);
    loadReg(5'd2, r);
    for (int f3 = 0; f3 < 8; f3++) begin
      sendInst(encR(7'h00, f3[2:0], 5'd3, 5'd1, 5'd2));
      if ((f3 == 0) || (f3 == 5)) begin
        sendInst(encR(7'h20, f3[2:0], 5'd4, 5'd1, 5'd2));  // SUB and SRA
      end
      randWord(12, r);
      if ((f3 == 1) || (f3 == 5)) begin
        r = {27'b0, r[4:0]};  // Shift amount only
      end
      sendInst(encI(r[11:0], f3[2:0], 5'd5, 5'd1));
      if (f3 == 5) begin
        sendInst(encI({7'h20, r[4:0]}, 3'b101, 5'd6, 5'd1));  // SRAI
      end
    end
    randWord(20, r);
    sendInst(encU(OpLui, r[19:0], 5'd7));
    randWord(20, r);
    sendInst(encU(OpAuipc, r[19:0], 5'd8));
  end
  drain();
endtask

// Consumer at distance 1 to 4, the last one only through write-through
task automatic forwardTest();
  logic [31:0] r;
  for (int d = 1; d <= 4; d++) begin
    randWord(32, r);
    loadReg(5'd10, r);
    randWord(12, r);
    sendInst(encI(r[11:0], 3'b000, 5'd12, 5'd10));  // Producer
    for (int k = 1; k < d; k++) begin
      sendInst(encI(12'(k), 3'b000, 5'd13, 5'd0));  // Unrelated filler
    end
    sendInst(encR(7'h00, 3'b000, 5'd14, 5'd12, 5'd12));
  end
  drain();
endtask

task automatic branchTest();
  logic [2:0]  branchF3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
  logic [31:0] r, a, b;
  for (int p = 0; p < 4; p++) begin
    randWord(32, r);
    case (p)
      0: begin
        a = r;
        b = r;
      end
      1: begin
        a = {2'b00, r[29:0]};
        b = a + 32'd1;
      end
      2: begin
        b = {2'b00, r[29:0]};
        a = b + 32'd1;
      end
      default: begin  // Negative against positive
        a = {1'b1, r[30:0]};
        b = {1'b0, r[31:1]};
      end
    endcase
    loadReg(5'd16, a);
    loadReg(5'd17, b);
    foreach (branchF3[i]) begin
      randWord(12, r);
      sendInst(encB(branchF3[i], 5'd16, 5'd17, {r[11:0], 1'b0}));
    end
  end
  drain();
endtask

task automatic zeroRegTest();
  logic [31:0] r;
  randWord(12, r);
  sendInst(encI(r[11:0], 3'b000, 5'd0, 5'd0));      // Write dropped
  sendInst(encR(7'h00, 3'b000, 5'd20, 5'd0, 5'd0));  // No forward from x0
  randWord(20, r);
  sendInst(encU(OpLui, r[19:0], 5'd0));
  sendInst(encI(12'd7, 3'b000, 5'd21, 5'd0));
  sendInst(encR(7'h00, 3'b110, 5'd22, 5'd0, 5'd0));
  sendInst(encR(7'h00, 3'b011, 5'd23, 5'd0, 5'd21));
  drain();
endtask

task automatic backPressureTest();
  logic [31:0] r;
  stallMode = 1'b1;
  randWord(32, r);
  loadReg(5'd24, r);
  randWord(32, r);
  loadReg(5'd25, r);
  for (int i = 0; i < 20; i++) begin
    randWord(3, r);
    sendInst(encR(7'h00, r[2:0], 5'd24, 5'd24, 5'd25));  // Chain through x24
    randWord(12, r);
    sendInst(encI(r[11:0], 3'b000, 5'd25, 5'd24));
  end
  drain();
  stallMode = 1'b0;
endtask

`default_nettype wire
`endif

// ==== bench/coreExeTb.sv ====
// Testbench for coreExeTop: clock, reset, reference model, result checking and timeout
`timescale 1ns/100ps
`default_nettype none

module coreExeTb;
  import coreExePkg::*;

  localparam int TotalInsts = 163;                  // Sum over all directed tests
  localparam int CycleLimit = TotalInsts * 8 + 200;

  logic   Clock;
  logic   arstN;
  logic   InstValid;
  logic   InstReady;
  tInst   InstData;
  logic   ResultValid;
  logic   ResultReady;
  tResult ResultData;

  logic [31:0] refRegs [32];      // Architectural state in program order
  tResult      expQ [$];          // Expected records, oldest first
  logic [31:0] curPc = 32'h0000_1000;
  logic [31:0] lfsrState = 32'h5cea;
  logic [31:0] gapState = 32'h5cea;  // Separate stream for output gaps
  logic        stallMode = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          sentCount = 0;
  int          recvCount = 0;

  coreExeTop #(.NumRegs(32)) dut0 (
    .Clock, .arstN, .InstValid, .InstReady, .InstData,
    .ResultValid, .ResultReady, .ResultData
  );

  initial begin : clockGen
    Clock = 1'b0;
    forever #50 Clock = ~Clock;
  end

  // ========================================
  // Random source and checking
  // ========================================
  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randWord(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrStep(lfsrState);
      v = {v[30:0], lfsrState[0]};  // One step per bit
    end
  endtask

  task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h actual %h", $time, what, expected, actual);
    end
  endtask

  task automatic compareResult(input tResult act, input tResult exp);
    string tag;
    tag = $sformatf("Pc %h", exp.Pc);
    check(act.Rd, exp.Rd, {tag, " Rd"});
    check(act.RegWrEn, exp.RegWrEn, {tag, " RegWrEn"});
    check(act.Data, exp.Data, {tag, " Data"});
    check(act.IsBranch, exp.IsBranch, {tag, " IsBranch"});
    check(act.BranchTaken, exp.BranchTaken, {tag, " BranchTaken"});
    check(act.PcPlus4, exp.PcPlus4, {tag, " PcPlus4"});
    check(act.Pc, exp.Pc, {tag, " Pc"});
  endtask

  // ========================================
  // Reference model from the RV32I rules
  // ========================================
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];  // Sign fill
        end else begin
          return a >> b[4:0];
        end
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic tResult modelExec(input logic [31:0] instr, input logic [31:0] pc);
    tResult      r;
    logic [31:0] a, b, immI, immU, immB;
    logic [2:0]  f3;
    a    = refRegs[instr[19:15]];
    b    = refRegs[instr[24:20]];
    f3   = instr[14:12];
    immI = {{20{instr[31]}}, instr[31:20]};
    immU = {instr[31:12], 12'b0};
    immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    r         = '0;
    r.Pc      = pc;
    r.PcPlus4 = pc + 32'd4;
    case (instr[6:0])
      7'b0110011: begin  // Register-register
        r.RegWrEn = 1'b1;
        r.Data    = aluRef(f3, instr[30], a, b);
      end
      7'b0010011: begin  // Only SRAI uses bit 30
        r.RegWrEn = 1'b1;
        r.Data    = aluRef(f3, instr[30] && (f3 == 3'b101), a, immI);
      end
      7'b0110111: begin
        r.RegWrEn = 1'b1;
        r.Data    = immU;
      end
      7'b0010111: begin
        r.RegWrEn = 1'b1;
        r.Data    = pc + immU;
      end
      7'b1100011: begin
        r.IsBranch    = 1'b1;
        r.BranchTaken = branchRef(f3, a, b);
        r.Data        = pc + immB;  // Target
      end
      default: ;
    endcase
    r.Rd = r.RegWrEn ? instr[11:7] : 5'd0;
    return r;
  endfunction

  // ========================================
  // Stream drivers and monitor
  // ========================================
  task automatic sendInst(input logic [31:0] instr);
    tResult exp;
    logic   accepted;
    exp = modelExec(instr, curPc);
    expQ.push_back(exp);
    if (exp.RegWrEn && (exp.Rd != 5'd0)) begin
      refRegs[exp.Rd] = exp.Data;  // x0 stays zero
    end
    InstData  = '{Instr: instr, Pc: curPc};
    InstValid = 1'b1;
    accepted  = 1'b0;
    while (!accepted) begin
      @(negedge Clock);
      accepted = InstReady;  // Transfer on the coming edge
      @(posedge Clock);
      #10;
    end
    InstValid = 1'b0;
    curPc += 32'd4;
    sentCount++;
  endtask

  task automatic drain();
    while (expQ.size() != 0) begin
      @(posedge Clock);
      #10;
    end
  endtask

  always @(posedge Clock) begin : readyGaps
    #10;
    if (stallMode) begin
      gapState    = lfsrStep(gapState);
      ResultReady = gapState[0];  // About half the cycles stall
    end else begin
      ResultReady = 1'b1;
    end
  end

  // Sampled mid-cycle before the record leaves on the next edge
  always @(negedge Clock) begin : monitor
    tResult exp;
    if (arstN && ResultValid && ResultReady) begin
      recvCount++;
      if (expQ.size() == 0) begin
        errors++;
        $display("Error at %0t: result record arrived with no instruction outstanding", $time);
      end else begin
        exp = expQ.pop_front();
        compareResult(ResultData, exp);
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CycleLimit) begin
      @(posedge Clock);
      cycles++;
    end
    $display("Timeout: results stopped arriving, %0d of %0d records received",
             recvCount, sentCount);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : main
    arstN       = 1'b0;
    InstValid   = 1'b0;
    InstData    = '0;
    ResultReady = 1'b1;
    foreach (refRegs[i]) begin
      refRegs[i] = '0;
    end
    repeat (3) @(posedge Clock);
    #10;
    arstN = 1'b1;
    resetStateTest();
    aluTest();
    forwardTest();
    branchTest();
    zeroRegTest();
    backPressureTest();
    drain();
    repeat (5) @(posedge Clock);  // Longer than the pipe, a stray record would show
    check(recvCount, sentCount, "record count");
    $display("Errors: %0d, checks: %0d, records: %0d", errors, checks, recvCount);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

`include "coreExeTests.svh"

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+bench
hw/coreExePkg.sv
hw/regFile.sv
hw/instDecode.sv
hw/intExecute.sv
hw/retireStage.sv
hw/coreExeTop.sv
bench/coreExeTb.sv

// ==== Bender.yml ====
package:
  name: core_exe

sources:
  - files:
      - hw/coreExePkg.sv
      - hw/regFile.sv
      - hw/instDecode.sv
      - hw/intExecute.sv
      - hw/retireStage.sv
      - hw/coreExeTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/coreExeTb.sv
